//--- imul_pkg.sv
// -----------------------------------------------
// shared widths, queue sizing and types for the
// signed iterative multiply unit
// -----------------------------------------------

package imul_pkg;

  // -----------------------------------------------
  // widths
  // -----------------------------------------------
  localparam int OPERAND_W = 32;
  localparam int PRODUCT_W = 2 * OPERAND_W;

  // split request layout is {neg, mag_a, mag_b}
  localparam int SPLIT_W       = 2 * OPERAND_W + 1;
  localparam int SPLIT_B_LSB   = 0;
  localparam int SPLIT_A_LSB   = SPLIT_B_LSB + OPERAND_W;
  localparam int SPLIT_NEG_BIT = SPLIT_A_LSB + OPERAND_W;

  // request queue sizing
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = 2;

  // one shift-and-add step per multiplier bit
  localparam int MUL_ITERS = OPERAND_W;

  // -----------------------------------------------
  // types
  // -----------------------------------------------
  typedef logic [OPERAND_W-1:0]   operand_t;
  typedef logic [OPERAND_W-1:0]   mag_t;
  typedef logic [PRODUCT_W-1:0]   product_t;
  typedef logic [SPLIT_W-1:0]     split_req_t;
  typedef logic [4:0]             count_t;

  // queue pointer and occupancy (occupancy needs one extra bit for full)
  typedef logic [QUEUE_PTR_W-1:0] qptr_t;
  typedef logic [QUEUE_PTR_W:0]   qcount_t;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } mul_state_t;

endpackage

//--- imul_sign_split.sv
// -----------------------------------------------
// front stage: turns a signed request into two
// magnitudes plus a result sign, one-entry buffer
// -----------------------------------------------
`timescale 1ns/1ps

module imul_sign_split (
  input  logic                  clk,
  input  logic                  reset,

  // request side
  input  imul_pkg::operand_t    req_a,
  input  imul_pkg::operand_t    req_b,
  input  logic                  req_val,
  output logic                  req_rdy,

  // toward the request queue
  output imul_pkg::split_req_t  split_msg,
  output logic                  split_val,
  input  logic                  split_rdy
);

  imul_pkg::split_req_t msg_r;
  imul_pkg::split_req_t msg_next;
  logic                 val_r;
  logic                 req_fire;
  logic                 sign_a;
  logic                 sign_b;

  // two's-complement magnitude, most negative input maps to 2^31
  function automatic imul_pkg::mag_t abs_val(input imul_pkg::operand_t x);
    if (x[imul_pkg::OPERAND_W-1]) begin
      return imul_pkg::mag_t'(~x + imul_pkg::operand_t'(1));
    end
    return imul_pkg::mag_t'(x);
  endfunction

  // accept when empty or when the held item leaves this cycle
  assign req_rdy  = !val_r || split_rdy;
  assign req_fire = req_val && req_rdy;

  assign sign_a = req_a[imul_pkg::OPERAND_W-1];
  assign sign_b = req_b[imul_pkg::OPERAND_W-1];

  // pack magnitudes and result sign into the split layout
  always_comb begin
    msg_next = '0;
    msg_next[imul_pkg::SPLIT_NEG_BIT]                      = sign_a ^ sign_b;
    msg_next[imul_pkg::SPLIT_A_LSB +: imul_pkg::OPERAND_W] = abs_val(req_a);
    msg_next[imul_pkg::SPLIT_B_LSB +: imul_pkg::OPERAND_W] = abs_val(req_b);
  end

  // -----------------------------------------------
  // output register
  // -----------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      val_r <= 1'b0;
    end else if (req_fire) begin
      val_r <= 1'b1;
    end else if (split_rdy) begin
      // drained with nothing new behind it
      val_r <= 1'b0;
    end
  end

  // payload only moves on an accept
  always_ff @(posedge clk) begin
    if (req_fire) begin
      msg_r <= msg_next;
    end
  end

  assign split_msg = msg_r;
  assign split_val = val_r;

endmodule

//--- imul_req_queue.sv
// -----------------------------------------------
// small circular FIFO between the sign splitter
// and the multiplier, no same-cycle bypass
// -----------------------------------------------
`timescale 1ns/1ps

module imul_req_queue (
  input  logic                  clk,
  input  logic                  reset,

  // write side
  input  imul_pkg::split_req_t  in_msg,
  input  logic                  in_val,
  output logic                  in_rdy,

  // read side
  output imul_pkg::split_req_t  out_msg,
  output logic                  out_val,
  input  logic                  out_rdy
);

  imul_pkg::split_req_t mem [imul_pkg::QUEUE_DEPTH];

  imul_pkg::qptr_t      wr_ptr;
  imul_pkg::qptr_t      rd_ptr;
  imul_pkg::qcount_t    count;

  logic                 full;
  logic                 empty;
  logic                 wr_fire;
  logic                 rd_fire;

  assign full  = (count == imul_pkg::qcount_t'(imul_pkg::QUEUE_DEPTH));
  assign empty = (count == '0);

  // a full queue still takes a write when the head leaves this cycle
  assign in_rdy  = !full || out_rdy;
  assign out_val = !empty;
  assign out_msg = mem[rd_ptr];

  assign wr_fire = in_val && in_rdy;
  assign rd_fire = out_val && out_rdy;

  // -----------------------------------------------
  // pointers and occupancy
  // -----------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointer width matches depth, wrap is implicit
      if (wr_fire) begin
        wr_ptr <= imul_pkg::qptr_t'(wr_ptr + imul_pkg::qptr_t'(1));
      end
      if (rd_fire) begin
        rd_ptr <= imul_pkg::qptr_t'(rd_ptr + imul_pkg::qptr_t'(1));
      end

      case ({wr_fire, rd_fire})
        2'b10: count <= imul_pkg::qcount_t'(count + imul_pkg::qcount_t'(1));
        2'b01: count <= imul_pkg::qcount_t'(count - imul_pkg::qcount_t'(1));
        // both or neither leaves occupancy alone
        default: count <= count;
      endcase
    end
  end

  // -----------------------------------------------
  // storage
  // -----------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= in_msg;
    end
  end

endmodule

//--- imul_ctrl.sv
// -----------------------------------------------
// multiplier FSM: takes a request from the queue,
// runs the shift-and-add steps, holds the response
// -----------------------------------------------
`timescale 1ns/1ps

module imul_ctrl (
  input  logic clk,
  input  logic reset,

  // queue side
  input  logic q_val,
  output logic q_rdy,

  // response side
  output logic resp_val,
  input  logic resp_rdy,

  // datapath controls
  output logic load_en,
  output logic step_en
);

  imul_pkg::mul_state_t state;
  imul_pkg::count_t     count;

  logic q_rdy_r;
  logic step_en_r;
  logic resp_val_r;
  logic q_fire;
  logic resp_fire;

  assign q_fire    = q_val && q_rdy_r;
  assign resp_fire = resp_val_r && resp_rdy;

  // load happens on the accept edge itself, the queue pops the same cycle
  assign load_en  = q_fire;
  assign q_rdy    = q_rdy_r;
  assign step_en  = step_en_r;
  assign resp_val = resp_val_r;

  // -----------------------------------------------
  // state, counter and registered handshake
  // -----------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= imul_pkg::IDLE;
      count      <= '0;
      q_rdy_r    <= 1'b0;
      step_en_r  <= 1'b0;
      resp_val_r <= 1'b0;
    end else begin
      case (state)
        imul_pkg::IDLE: begin
          // ready comes up one cycle out of reset
          q_rdy_r <= 1'b1;
          if (q_fire) begin
            state     <= imul_pkg::CALC;
            count     <= '0;
            q_rdy_r   <= 1'b0;
            step_en_r <= 1'b1;
          end
        end

        imul_pkg::CALC: begin
          // one step per cycle, count tracks which bit of b is consumed
          count <= imul_pkg::count_t'(count + imul_pkg::count_t'(1));
          if (count == imul_pkg::count_t'(imul_pkg::MUL_ITERS - 1)) begin
            state     <= imul_pkg::DONE;
            step_en_r <= 1'b0;
          end
        end

        imul_pkg::DONE: begin
          // first DONE cycle lets the sign fix settle, then valid rises
          if (resp_fire) begin
            state      <= imul_pkg::IDLE;
            resp_val_r <= 1'b0;
            q_rdy_r    <= 1'b1;
          end else begin
            resp_val_r <= 1'b1;
          end
        end

        default: begin
          state      <= imul_pkg::IDLE;
          q_rdy_r    <= 1'b0;
          step_en_r  <= 1'b0;
          resp_val_r <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- imul_dpath.sv
// -----------------------------------------------
// iterative multiplier datapath: shift registers,
// accumulator and the final sign correction
// -----------------------------------------------
`timescale 1ns/1ps

module imul_dpath (
  input  logic                  clk,
  input  logic                  reset,

  // request payload from the queue head
  input  imul_pkg::split_req_t  q_msg,

  // controls
  input  logic                  load_en,
  input  logic                  step_en,

  output imul_pkg::product_t    resp_result
);

  // multiplicand widened so it can shift left 31 times
  imul_pkg::product_t a_reg;
  imul_pkg::mag_t     b_reg;
  imul_pkg::product_t acc;
  logic               neg_reg;

  imul_pkg::mag_t     msg_a;
  imul_pkg::mag_t     msg_b;
  logic               msg_neg;
  imul_pkg::product_t acc_next;

  // -----------------------------------------------
  // unpack the split request
  // -----------------------------------------------
  assign msg_a   = q_msg[imul_pkg::SPLIT_A_LSB +: imul_pkg::OPERAND_W];
  assign msg_b   = q_msg[imul_pkg::SPLIT_B_LSB +: imul_pkg::OPERAND_W];
  assign msg_neg = q_msg[imul_pkg::SPLIT_NEG_BIT];

  // add the shifted multiplicand only when the current b bit is set
  assign acc_next = b_reg[0] ? imul_pkg::product_t'(acc + a_reg) : acc;

  // -----------------------------------------------
  // accumulator and result sign
  // -----------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      // response bus reads zero until the first product
      acc     <= '0;
      neg_reg <= 1'b0;
    end else if (load_en) begin
      acc     <= '0;
      neg_reg <= msg_neg;
    end else if (step_en) begin
      acc     <= acc_next;
    end
  end

  // -----------------------------------------------
  // operand shift registers
  // -----------------------------------------------
  always_ff @(posedge clk) begin
    if (load_en) begin
      a_reg <= imul_pkg::product_t'(msg_a);
      b_reg <= msg_b;
    end else if (step_en) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // magnitudes top out at 2^31 each, so the product never reaches bit 63
  // before negation
  assign resp_result = neg_reg ? imul_pkg::product_t'(~acc + imul_pkg::product_t'(1))
                               : acc;

endmodule

//--- imul_top.sv
// -----------------------------------------------
// signed 32x32 multiply unit: splitter, request
// queue and iterative multiplier
// -----------------------------------------------
`timescale 1ns/1ps

module imul_top (
  input  logic                clk,
  input  logic                reset,

  // request side
  input  imul_pkg::operand_t  req_a,
  input  imul_pkg::operand_t  req_b,
  input  logic                req_val,
  output logic                req_rdy,

  // response side
  output imul_pkg::product_t  resp_result,
  output logic                resp_val,
  input  logic                resp_rdy
);

  // splitter to queue
  imul_pkg::split_req_t split_msg;
  logic                 split_val;
  logic                 split_rdy;

  // queue to multiplier
  imul_pkg::split_req_t q_msg;
  logic                 q_val;
  logic                 q_rdy;

  // control to datapath
  logic                 load_en;
  logic                 step_en;

  imul_sign_split u_split (
    .clk       (clk),
    .reset     (reset),
    .req_a     (req_a),
    .req_b     (req_b),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .split_msg (split_msg),
    .split_val (split_val),
    .split_rdy (split_rdy)
  );

  imul_req_queue u_queue (
    .clk     (clk),
    .reset   (reset),
    .in_msg  (split_msg),
    .in_val  (split_val),
    .in_rdy  (split_rdy),
    .out_msg (q_msg),
    .out_val (q_val),
    .out_rdy (q_rdy)
  );

  imul_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .q_val    (q_val),
    .q_rdy    (q_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load_en  (load_en),
    .step_en  (step_en)
  );

  imul_dpath u_dpath (
    .clk         (clk),
    .reset       (reset),
    .q_msg       (q_msg),
    .load_en     (load_en),
    .step_en     (step_en),
    .resp_result (resp_result)
  );

endmodule

//--- imul_tb.sv
// --------------------------------------------------
// self-checking testbench for the signed multiply
// unit; run through sources.f with imul_tb as top
// --------------------------------------------------
`timescale 1ns/1ps

module imul_tb;

  // edges from an accept to resp_val on an empty pipe are the queue write,
  // the load, 32 steps and one settle edge
  localparam int IDLE_LATENCY    = imul_pkg::MUL_ITERS + 3;
  localparam int TOTAL_REQS      = 7 + 1 + 40 + 6 + 30;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 40 + 1000;
  // six requests in flight with random stalls come back well inside this
  localparam int DRAIN_LIMIT     = 8 * 2 * IDLE_LATENCY;
  localparam logic [31:0] SEED   = 32'h545716f0;

  // directed pairs (3,5) (-3,5) (3,-5) (-3,-5) (0,-7) (-1,max) (min,min)
  localparam imul_pkg::operand_t DIR_A [7] = '{32'h3, 32'hffff_fffd, 32'h3,
    32'hffff_fffd, 32'h0, 32'hffff_ffff, 32'h8000_0000};
  localparam imul_pkg::operand_t DIR_B [7] = '{32'h5, 32'h5, 32'hffff_fffb,
    32'hffff_fffb, 32'hffff_fff9, 32'h7fff_ffff, 32'h8000_0000};

  logic               clk;
  logic               reset;
  imul_pkg::operand_t req_a;
  imul_pkg::operand_t req_b;
  logic               req_val;
  logic               req_rdy;
  imul_pkg::product_t resp_result;
  logic               resp_val;
  logic               resp_rdy;

  // expected products of accepted requests, oldest first
  imul_pkg::product_t sb [$];
  imul_pkg::product_t resp_expected;
  logic [31:0]        rng;
  logic               rdy_random;
  string              test_name;
  int                 error_count;
  int                 errors_at_start;
  int                 tests_run;
  int                 tests_failed;
  int                 k;
  int                 accepts;

  imul_top DUT (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // full signed product of the sign-extended operands
  function automatic imul_pkg::product_t signed_product(input imul_pkg::operand_t a,
                                                        input imul_pkg::operand_t b);
    logic signed [63:0] wa;
    logic signed [63:0] wb;
    wa = {{32{a[31]}}, a};
    wb = {{32{b[31]}}, b};
    return imul_pkg::product_t'(wa * wb);
  endfunction

  // --------------------------------------------------
  // stimulus helpers called on a falling edge
  // --------------------------------------------------
  task automatic next_cycle;
    @(negedge clk);
    // random back-pressure only in the last test
    if (rdy_random) begin
      rng = xorshift32(rng);
      resp_rdy = rng[7];
    end
  endtask

  task automatic send_req(input imul_pkg::operand_t a, input imul_pkg::operand_t b);
    logic accepted;
    accepted = 1'b0;
    req_a = a;
    req_b = b;
    req_val = 1'b1;
    while (!accepted) begin
      @(posedge clk);
      accepted = req_rdy;
      next_cycle();
    end
    req_val = 1'b0;
  endtask

  task automatic send_random(input int n);
    imul_pkg::operand_t a;
    imul_pkg::operand_t b;
    repeat (n) begin
      rng = xorshift32(rng);
      a = rng;
      rng = xorshift32(rng);
      b = rng;
      send_req(a, b);
    end
  endtask

  // wait until every accepted request has been answered
  task automatic drain;
    while (sb.size() != 0) next_cycle();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test;
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("PASS  %s", test_name);
    end else begin
      tests_failed++;
      $display("FAIL  %s", test_name);
    end
  endtask

  // --------------------------------------------------
  // scoreboard pushes on a request accept and compares on a response
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!reset) begin
      if (req_val && req_rdy) sb.push_back(signed_product(req_a, req_b));
      if (resp_val && resp_rdy) begin
        if (sb.size() == 0) begin
          error_count++;
          $display("%s: a response arrived with no request outstanding", test_name);
        end else begin
          resp_expected = sb.pop_front();
          assert (resp_result == resp_expected) else begin
            error_count++;
            $display("Error: %s expected %h actual %h", test_name, resp_expected, resp_result);
          end
        end
      end
    end
  end

  // a stalled response keeps its valid and its value
  hold_stable: assert property (@(posedge clk) disable iff (reset)
      (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else begin
      error_count++;
      $display("%s: the response changed or dropped while stalled", test_name);
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    reset = 1'b1;
    req_a = '0;
    req_b = '0;
    req_val = 1'b0;
    resp_rdy = 1'b1;
    rdy_random = 1'b0;
    rng = SEED;
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    next_cycle();
    reset = 1'b0;

    begin_test("reset");
    next_cycle();
    assert (!resp_val && req_rdy) else begin
      error_count++;
      $display("after reset resp_val should be low and req_rdy high");
    end
    end_test();

    begin_test("directed");
    for (int i = 0; i < 7; i++) send_req(DIR_A[i], DIR_B[i]);
    drain();
    end_test();

    begin_test("idle_latency");
    send_req(32'hffff_fff3, 32'h0000_1234);
    // k counts falling edges after the accepting rising edge
    k = 0;
    while (!resp_val && k < 2 * IDLE_LATENCY) begin
      next_cycle();
      k++;
    end
    assert (k == IDLE_LATENCY) else begin
      error_count++;
      $display("Error: %s expected %0d actual %0d", test_name, IDLE_LATENCY, k);
    end
    drain();
    end_test();

    begin_test("random_stream");
    send_random(40);
    drain();
    end_test();

    begin_test("back_pressure");
    resp_rdy = 1'b0;
    accepts = 0;
    rng = xorshift32(rng);
    req_a = rng;
    rng = xorshift32(rng);
    req_b = rng;
    req_val = 1'b1;
    // offer on every cycle and change operands only after an accept
    for (int i = 0; i < 60; i++) begin
      @(posedge clk);
      k = req_rdy ? 1 : 0;
      accepts += k;
      next_cycle();
      if (k == 1) begin
        rng = xorshift32(rng);
        req_a = rng;
        rng = xorshift32(rng);
        req_b = rng;
      end
    end
    req_val = 1'b0;
    assert (accepts == 6) else begin
      error_count++;
      $display("Error: %s expected %0d actual %0d", test_name, 6, accepts);
    end
    assert (!req_rdy && resp_val) else begin
      error_count++;
      $display("%s: req_rdy stayed high or no response was waiting", test_name);
    end
    repeat (10) next_cycle();
    resp_rdy = 1'b1;
    drain();
    end_test();

    begin_test("random_resp_rdy");
    rdy_random = 1'b1;
    send_random(30);
    // give the requests still in flight a bounded time to come back
    k = 0;
    while (sb.size() != 0 && k < DRAIN_LIMIT) begin
      next_cycle();
      k++;
    end
    rdy_random = 1'b0;
    resp_rdy = 1'b1;
    // a duplicated response would show up here
    repeat (40) next_cycle();
    assert (sb.size() == 0 && !resp_val) else begin
      error_count++;
      $display("responses were lost or duplicated in %s", test_name);
    end
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sources.f
imul_pkg.sv
imul_sign_split.sv
imul_req_queue.sv
imul_ctrl.sv
imul_dpath.sv
imul_top.sv
imul_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module imul_tb \
  --Mdir obj_dir -o imul_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output="$(./obj_dir/imul_sim)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
  exit 0
fi

echo "simulation reported failures"
exit 1
